// ==== include/dmm_params.svh ====
/*
  widths, register map, mode codes and analog mux codes for the dmm control fpga
  cap test phase length is in clk cycles, kept short here for simulation
  on the board it is about one second of clk
*/
`ifndef DMM_PARAMS_SVH
`define DMM_PARAMS_SVH

// widths
`define DMM_OUT_BITS          22
`define DMM_REG_BITS          24
`define DMM_ADDR_BITS         8
`define DMM_NUM_PERIPH        8

// strobe active level per peripheral, only the 4094 on channel 0 strobes high
`define DMM_PERIPH_CS_POL     8'b0000_0001

// register addresses, bit 7 of the frame address marks a read
`define DMM_ADDR_LED          8'd7
`define DMM_ADDR_SPI_MUX      8'd8
`define DMM_ADDR_MODE         8'd9
`define DMM_ADDR_DIRECT       8'd10

// mode codes, low two bits of the mode register
`define DMM_MODE_DIRECT       2'd0
`define DMM_MODE_PATTERN      2'd1
`define DMM_MODE_CAP_TEST     2'd2
`define DMM_MODE_OFF          2'd3

// cap test
`define DMM_CAP_PHASE_CLKS    20

// mux codes are {en, a2, a1, a0}
`define DMM_HIMUX_SEL_HIMUX2  4'b1001
`define DMM_HIMUX2_SEL_GND    4'b1011
`define DMM_HIMUX2_SEL_DCV    4'b1000

`endif

// ==== verilog/dmm_pkg.sv ====
/*
  shared types for the dmm control fpga
  widths come from the params header
*/
`include "dmm_params.svh"

package dmm_pkg;

  // one spi register
  typedef logic [`DMM_REG_BITS-1:0] reg_word_t;

  // output word, low to high: azmux, himux, himux2, pc switch, led, monitor
  typedef logic [`DMM_OUT_BITS-1:0] out_word_t;

  // one bit per peripheral channel
  typedef logic [`DMM_NUM_PERIPH-1:0] periph_vec_t;

  // analog mux control, enable then a2..a0
  typedef logic [3:0] mux_code_t;

  typedef enum logic [1:0]
  {
    MODE_DIRECT   = `DMM_MODE_DIRECT,
    MODE_PATTERN  = `DMM_MODE_PATTERN,
    MODE_CAP_TEST = `DMM_MODE_CAP_TEST,
    MODE_OFF      = `DMM_MODE_OFF
  } dmm_mode_t;

endpackage

// ==== verilog/spi_regbank.sv ====
/*
  spi slave register bank, mode 0, msb first, 8 bit address then 24 data bits
  a write lands on the cs rising edge only after exactly 32 bits
  registers live in the spi_clk / spi_cs domain, readers must synchronize
*/
`timescale 1ns/1ps
`include "dmm_params.svh"

module spi_regbank (
  input  logic                 reset,
  input  logic                 spi_clk,
  input  logic                 spi_cs,
  input  logic                 spi_mosi,
  output logic                 dout,
  output dmm_pkg::reg_word_t   reg_led,
  output dmm_pkg::periph_vec_t reg_spi_mux,
  output dmm_pkg::reg_word_t   reg_mode,
  output dmm_pkg::reg_word_t   reg_direct
);
  import dmm_pkg::*;

  localparam int FRAME_BITS = `DMM_ADDR_BITS + `DMM_REG_BITS;
  localparam int CNT_BITS   = $clog2(FRAME_BITS) + 1;

  logic                      frame_clr;
  logic [CNT_BITS-1:0]       bit_cnt;
  logic [FRAME_BITS-1:0]     shift_in;
  reg_word_t                 dout_sr;
  reg_word_t                 rd_data;
  logic [`DMM_ADDR_BITS-1:0] rd_addr;
  logic [`DMM_ADDR_BITS-1:0] wr_addr;
  reg_word_t                 wr_data;

  // deselect clears the frame state
  assign frame_clr = reset | spi_cs;

  ////////////////////////////////////////
  // receive side

  // saturates so an overlong frame never wraps back to 32
  always_ff @(posedge spi_clk or posedge frame_clr)
  begin
    if (frame_clr)
      bit_cnt <= '0;
    else if (bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge spi_clk)
  begin
    if (!spi_cs)
      shift_in <= {shift_in[FRAME_BITS-2:0], spi_mosi};
  end

  // after 8 bits the address sits in the low byte, read flag ignored
  assign rd_addr = {1'b0, shift_in[`DMM_ADDR_BITS-2:0]};
  // at the cs edge the whole frame is in
  assign wr_addr = shift_in[FRAME_BITS-1 -: `DMM_ADDR_BITS];
  assign wr_data = shift_in[`DMM_REG_BITS-1:0];

  ////////////////////////////////////////
  // readback

  always_comb
  begin
    case (rd_addr)
      `DMM_ADDR_LED:     rd_data = reg_led;
      `DMM_ADDR_SPI_MUX: rd_data = reg_word_t'(reg_spi_mux);
      `DMM_ADDR_MODE:    rd_data = reg_mode;
      `DMM_ADDR_DIRECT:  rd_data = reg_direct;
      default:           rd_data = '0;
    endcase
  end

  // load on the falling edge after the address, so the master sees
  // data bit 23 at its 9th rising edge, then shift on each falling edge
  always_ff @(negedge spi_clk or posedge frame_clr)
  begin
    if (frame_clr)
      dout_sr <= '0;
    else if (bit_cnt == CNT_BITS'(`DMM_ADDR_BITS))
      dout_sr <= rd_data;
    else
      dout_sr <= {dout_sr[`DMM_REG_BITS-2:0], 1'b0};
  end

  assign dout = dout_sr[`DMM_REG_BITS-1];

  ////////////////////////////////////////
  // commit on deselect

  // bit_cnt still holds the frame length here, it clears in the same edge
  always_ff @(posedge spi_cs or posedge reset)
  begin
    if (reset)
    begin
      reg_led     <= '0;
      reg_spi_mux <= '0;
      reg_mode    <= '0;
      reg_direct  <= '0;
    end
    else if (bit_cnt == CNT_BITS'(FRAME_BITS) && !wr_addr[`DMM_ADDR_BITS-1])
    begin
      case (wr_addr)
        `DMM_ADDR_LED:     reg_led     <= wr_data;
        `DMM_ADDR_SPI_MUX: reg_spi_mux <= wr_data[`DMM_NUM_PERIPH-1:0];
        `DMM_ADDR_MODE:    reg_mode    <= wr_data;
        `DMM_ADDR_DIRECT:  reg_direct  <= wr_data;
        default: ;
      endcase
    end
  end

endmodule

// ==== verilog/periph_spi_mux.sv ====
/*
  spi pass-through to one of the peripheral channels on spi_cs2
  lowest set bit of the select register wins, no select means no channel
  purely combinational, strobe polarity is fixed per channel
*/
`timescale 1ns/1ps
`include "dmm_params.svh"

module periph_spi_mux (
  input  logic                 spi_clk,
  input  logic                 spi_mosi,
  input  logic                 spi_cs,
  input  logic                 spi_cs2,
  input  dmm_pkg::periph_vec_t reg_spi_mux,
  input  logic                 regbank_dout,
  input  dmm_pkg::periph_vec_t periph_miso,
  output dmm_pkg::periph_vec_t periph_cs,
  output dmm_pkg::periph_vec_t periph_clk,
  output dmm_pkg::periph_vec_t periph_mosi,
  output logic                 miso
);
  import dmm_pkg::*;

  periph_vec_t sel;
  periph_vec_t sel_act;

  // isolate lowest set bit
  assign sel     = reg_spi_mux & (~reg_spi_mux + 1'b1);
  assign sel_act = spi_cs2 ? '0 : sel;

  // selected strobe at its active level, the rest inactive
  assign periph_cs   = ~(periph_vec_t'(`DMM_PERIPH_CS_POL) ^ sel_act);
  // idle channels hold clock and data low
  assign periph_clk  = sel_act & {`DMM_NUM_PERIPH{spi_clk}};
  assign periph_mosi = sel_act & {`DMM_NUM_PERIPH{spi_mosi}};

  // bank first, then the selected channel
  assign miso = !spi_cs  ? regbank_dout :
                !spi_cs2 ? |(sel_act & periph_miso) :
                1'b0;

endmodule

// ==== verilog/pattern_gen.sv ====
/*
  free-running count over the whole output word, for pin and wiring checks
  start restarts at zero, the count holds while run is low
*/
`timescale 1ns/1ps

module pattern_gen (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               run,
  output dmm_pkg::out_word_t pattern
);
  import dmm_pkg::*;

  out_word_t count;

  // wraps naturally at the word width
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      count <= '0;
    else if (start)
      count <= '0;
    else if (run)
      count <= count + 1'b1;
  end

  // the output register downstream adds the cycle
  assign pattern = count;

endmodule

// ==== verilog/cap_test_seq.sv ====
/*
  accumulation cap charge test, two equal phases repeating
  phase a grounds the cap through himux2, phase b switches it to dcv and lights the led
  phase length is DMM_CAP_PHASE_CLKS clk cycles, at least 1
*/
`timescale 1ns/1ps
`include "dmm_params.svh"

module cap_test_seq (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               run,
  output dmm_pkg::out_word_t seq_word
);
  import dmm_pkg::*;

  localparam int PHASE_CLKS = `DMM_CAP_PHASE_CLKS;
  localparam int CNT_BITS   = $clog2(PHASE_CLKS + 1);
  localparam int MON_BITS   = `DMM_OUT_BITS - 14;

  logic [CNT_BITS-1:0] phase_cnt;
  logic                phase_b;
  mux_code_t           himux2;
  logic                led;

  ////////////////////////////////////////
  // phase timing

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase_cnt <= '0;
      phase_b   <= 1'b0;
    end
    else if (start)
    begin
      phase_cnt <= '0;
      phase_b   <= 1'b0;
    end
    else if (run)
    begin
      // last cycle of the phase, flip to the other one
      if (phase_cnt == CNT_BITS'(PHASE_CLKS - 1))
      begin
        phase_cnt <= '0;
        phase_b   <= ~phase_b;
      end
      else
        phase_cnt <= phase_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // output fields

  // ground clears the cap, dcv charges it
  assign himux2 = phase_b ? `DMM_HIMUX2_SEL_DCV : `DMM_HIMUX2_SEL_GND;
  assign led    = phase_b;

  // monitor quiet, precharge open, himux routes through himux2, azmux off
  assign seq_word = {{MON_BITS{1'b0}}, led, 1'b0, himux2, `DMM_HIMUX_SEL_HIMUX2, 4'b0000};

endmodule

// ==== verilog/mode_ctrl.sv ====
/*
  brings the mode and direct registers into the clk domain and drives out_word
  two flop capture with no handshake, so the registers may only change while
  the mode is being rewritten; output latency is 3 to 4 clk after the spi write
*/
`timescale 1ns/1ps
`include "dmm_params.svh"

module mode_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  dmm_pkg::reg_word_t reg_mode,
  input  dmm_pkg::reg_word_t reg_direct,
  input  dmm_pkg::out_word_t pattern,
  input  dmm_pkg::out_word_t seq_word,
  output logic               pattern_start,
  output logic               pattern_run,
  output logic               seq_start,
  output logic               seq_run,
  output dmm_pkg::out_word_t out_word
);
  import dmm_pkg::*;

  reg_word_t mode_meta;
  reg_word_t mode_sync;
  reg_word_t direct_meta;
  reg_word_t direct_sync;
  dmm_mode_t mode_next;
  dmm_mode_t mode_q;

  ////////////////////////////////////////
  // capture

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mode_meta   <= '0;
      mode_sync   <= '0;
      direct_meta <= '0;
      direct_sync <= '0;
      mode_q      <= MODE_DIRECT;
    end
    else
    begin
      mode_meta   <= reg_mode;
      mode_sync   <= mode_meta;
      direct_meta <= reg_direct;
      direct_sync <= direct_meta;
      mode_q      <= mode_next;
    end
  end

  // only the low two bits select the mode
  assign mode_next = dmm_mode_t'(mode_sync[1:0]);

  ////////////////////////////////////////
  // strobes

  // start fires the cycle before the mode state moves to the new mode
  assign pattern_start = (mode_next == MODE_PATTERN) && (mode_q != MODE_PATTERN);
  assign seq_start     = (mode_next == MODE_CAP_TEST) && (mode_q != MODE_CAP_TEST);
  assign pattern_run   = (mode_q == MODE_PATTERN);
  assign seq_run       = (mode_q == MODE_CAP_TEST);

  // output register, loads every cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      out_word <= '0;
    else
    begin
      case (mode_q)
        MODE_DIRECT:   out_word <= direct_sync[`DMM_OUT_BITS-1:0];
        MODE_PATTERN:  out_word <= pattern;
        MODE_CAP_TEST: out_word <= seq_word;
        default:       out_word <= '0;
      endcase
    end
  end

endmodule

// ==== verilog/dmm_top.sv ====
/*
  dmm front end control fpga top level
  spi_cs selects the register bank, spi_cs2 the peripheral pass-through
  4094 output enable is tied high on the board, not driven here
*/
`timescale 1ns/1ps

module dmm_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 spi_clk,
  input  logic                 spi_cs,
  input  logic                 spi_mosi,
  input  logic                 spi_cs2,
  output logic                 spi_miso,
  input  dmm_pkg::periph_vec_t periph_miso,
  output dmm_pkg::periph_vec_t periph_cs,
  output dmm_pkg::periph_vec_t periph_clk,
  output dmm_pkg::periph_vec_t periph_mosi,
  output logic                 led0,
  output logic                 pc_sw_ctl,
  output dmm_pkg::mux_code_t   himux,
  output dmm_pkg::mux_code_t   himux2,
  output dmm_pkg::mux_code_t   azmux,
  output logic [7:0]           monitor
);
  import dmm_pkg::*;

  logic        regbank_dout;
  periph_vec_t reg_spi_mux;
  reg_word_t   reg_mode;
  reg_word_t   reg_direct;
  out_word_t   pattern;
  out_word_t   seq_word;
  out_word_t   out_word;
  logic        pattern_start;
  logic        pattern_run;
  logic        seq_start;
  logic        seq_run;

  ////////////////////////////////////////
  // spi side

  // the led register is a scratch register, readback only
  spi_regbank regbank0 (
    .reset       (reset),
    .spi_clk     (spi_clk),
    .spi_cs      (spi_cs),
    .spi_mosi    (spi_mosi),
    .dout        (regbank_dout),
    .reg_led     (),
    .reg_spi_mux (reg_spi_mux),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct)
  );

  periph_spi_mux periph_mux0 (
    .spi_clk      (spi_clk),
    .spi_mosi     (spi_mosi),
    .spi_cs       (spi_cs),
    .spi_cs2      (spi_cs2),
    .reg_spi_mux  (reg_spi_mux),
    .regbank_dout (regbank_dout),
    .periph_miso  (periph_miso),
    .periph_cs    (periph_cs),
    .periph_clk   (periph_clk),
    .periph_mosi  (periph_mosi),
    .miso         (spi_miso)
  );

  ////////////////////////////////////////
  // clk side

  pattern_gen pattern0 (
    .clk     (clk),
    .reset   (reset),
    .start   (pattern_start),
    .run     (pattern_run),
    .pattern (pattern)
  );

  cap_test_seq cap_seq0 (
    .clk      (clk),
    .reset    (reset),
    .start    (seq_start),
    .run      (seq_run),
    .seq_word (seq_word)
  );

  mode_ctrl mode_ctrl0 (
    .clk           (clk),
    .reset         (reset),
    .reg_mode      (reg_mode),
    .reg_direct    (reg_direct),
    .pattern       (pattern),
    .seq_word      (seq_word),
    .pattern_start (pattern_start),
    .pattern_run   (pattern_run),
    .seq_start     (seq_start),
    .seq_run       (seq_run),
    .out_word      (out_word)
  );

  // split into pin groups, low to high
  assign {monitor, led0, pc_sw_ctl, himux2, himux, azmux} = out_word;

endmodule

// ==== tb/dmm_checker.sv ====
/*
  concurrent checks bound into dmm_top
  all sampled on clk, so spi activity between clk edges is not seen
*/
`timescale 1ns/1ps
`include "dmm_params.svh"

module dmm_checker (
  input logic                 clk,
  input logic                 reset,
  input logic                 spi_cs,
  input logic                 spi_cs2,
  input logic                 spi_miso,
  input logic                 regbank_dout,
  input dmm_pkg::periph_vec_t periph_cs,
  input logic                 pattern_run,
  input dmm_pkg::out_word_t   out_word
);

  // inactive level of every strobe
  localparam dmm_pkg::periph_vec_t CS_IDLE = ~(`DMM_PERIPH_CS_POL);

  ////////////////////////////////////////
  // spi side

  idle_strobes: assert property (@(posedge clk) disable iff (reset)
    spi_cs2 |-> periph_cs == CS_IDLE)
    else $error("peripheral strobe active while spi_cs2 is high");

  bank_miso: assert property (@(posedge clk) disable iff (reset)
    !spi_cs |-> spi_miso == regbank_dout)
    else $error("spi_miso does not follow the register bank during a frame");

  ////////////////////////////////////////
  // pattern mode

  // first two pattern cycles still carry the entry, then one step per clk
  pattern_step: assert property (@(posedge clk) disable iff (reset)
    pattern_run && $past(pattern_run) && $past(pattern_run, 2)
      |-> out_word == $past(out_word) + 1'b1)
    else $error("pattern output did not step by one");

endmodule

// ==== tb/tb_dmm.sv ====
/*
  testbench for dmm_top, spi_clk runs at a quarter of clk
  all inputs change on the falling clk edge, outputs are read on the next edge
  cap test checks assume the default short phase length
*/
`timescale 1ns/1ps
`include "dmm_params.svh"

module tb_dmm;
  import dmm_pkg::*;

  localparam int          WAIT_CLKS  = 40;
  localparam int          PHASE_CLKS = `DMM_CAP_PHASE_CLKS;
  localparam logic [31:0] SEED       = 32'hb281_6130;
  localparam periph_vec_t CS_POL     = `DMM_PERIPH_CS_POL;
  localparam periph_vec_t CS_IDLE    = ~CS_POL;

  logic        clk;
  logic        reset;
  logic        spi_clk;
  logic        spi_cs;
  logic        spi_mosi;
  logic        spi_cs2;
  logic        spi_miso;
  periph_vec_t periph_miso;
  periph_vec_t periph_cs;
  periph_vec_t periph_clk;
  periph_vec_t periph_mosi;
  logic        led0;
  logic        pc_sw_ctl;
  mux_code_t   himux;
  mux_code_t   himux2;
  mux_code_t   azmux;
  logic [7:0]  monitor;
  out_word_t   pins;

  logic [31:0] rng;
  int          tests;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;

  // compare process state
  logic        watch_pattern;
  logic        watch_cap;
  logic        armed;
  out_word_t   prev_word;
  int          phase_idx;
  int          run_len;
  int          phase_changes;
  int          samples;

  dmm_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .spi_clk     (spi_clk),
    .spi_cs      (spi_cs),
    .spi_mosi    (spi_mosi),
    .spi_cs2     (spi_cs2),
    .spi_miso    (spi_miso),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .periph_clk  (periph_clk),
    .periph_mosi (periph_mosi),
    .led0        (led0),
    .pc_sw_ctl   (pc_sw_ctl),
    .himux       (himux),
    .himux2      (himux2),
    .azmux       (azmux),
    .monitor     (monitor)
  );

  bind dmm_top dmm_checker checker0 (
    .clk          (clk),
    .reset        (reset),
    .spi_cs       (spi_cs),
    .spi_cs2      (spi_cs2),
    .spi_miso     (spi_miso),
    .regbank_dout (regbank_dout),
    .periph_cs    (periph_cs),
    .pattern_run  (pattern_run),
    .out_word     (out_word)
  );

  // pin groups back into one word, low to high
  assign pins = {monitor, led0, pc_sw_ctl, himux2, himux, azmux};

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // expected pins, idx is the count in pattern mode and the phase in cap test
  function automatic out_word_t expected_word(input dmm_mode_t mode, input reg_word_t direct,
                                              input int unsigned idx);
    out_word_t w;
    w = '0;
    case (mode)
      MODE_DIRECT:  w = direct[`DMM_OUT_BITS-1:0];
      MODE_PATTERN: w = out_word_t'(idx);
      MODE_CAP_TEST:
      begin
        w[7:4] = `DMM_HIMUX_SEL_HIMUX2;
        // odd phases charge from dcv with the led lit
        if (idx[0])
        begin
          w[11:8] = `DMM_HIMUX2_SEL_DCV;
          w[13]   = 1'b1;
        end
        else
          w[11:8] = `DMM_HIMUX2_SEL_GND;
      end
      default: w = '0;
    endcase
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    test_checks++;
    if (expected !== actual)
    begin
      errors++;
      test_errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    tests++;
    test_checks = 0;
    test_errors = 0;
  endtask

  // one frame, msb first, nbits of it; rx holds what came back on miso
  task automatic spi_frame(input logic [31:0] frame, input int nbits,
                           output logic [31:0] rx);
    logic [31:0] sr;
    sr = frame;
    rx = '0;
    @(negedge clk);
    spi_cs = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      @(negedge clk);
      spi_mosi = sr[31];
      sr = sr << 1;
      // miso settled since the last spi_clk fall
      @(negedge clk);
      rx = {rx[30:0], spi_miso};
      spi_clk = 1'b1;
      @(negedge clk);
      @(negedge clk);
      spi_clk = 1'b0;
    end
    @(negedge clk);
    spi_cs = 1'b1;
    spi_mosi = 1'b0;
    @(negedge clk);
  endtask

  task automatic spi_write(input logic [7:0] addr, input reg_word_t data);
    logic [31:0] rx;
    spi_frame({addr, data}, 32, rx);
  endtask

  task automatic read_and_check(input string name, input logic [7:0] addr,
                                input reg_word_t expected);
    logic [31:0] rx;
    spi_frame({addr | 8'h80, 24'h000000}, 32, rx);
    check(name, 32'(expected), 32'(rx[23:0]));
  endtask

  // polls each clk until the pins match or the wait runs out
  task automatic wait_for_pins(input string name, input out_word_t expected);
    int n;
    n = 0;
    while (pins !== expected && n < WAIT_CLKS)
    begin
      @(negedge clk);
      n++;
    end
    if (pins !== expected)
      $display("timeout: %s never reached %h within %0d clk", name, expected, WAIT_CLKS);
    check(name, 32'(expected), 32'(pins));
  endtask

  function automatic periph_vec_t channel_vec(input logic [2:0] ch, input logic v);
    periph_vec_t vec;
    vec = '0;
    vec[ch] = v;
    return vec;
  endfunction

  ////////////////////////////////////////
  // compare process for the free-running modes

  always @(negedge clk)
  begin
    if (!watch_pattern && !watch_cap)
      armed = 1'b0;
    else if (!armed)
    begin
      // first sample only sets the reference point
      armed         = 1'b1;
      prev_word     = pins;
      phase_idx     = (pins == expected_word(MODE_CAP_TEST, '0, 1)) ? 1 : 0;
      run_len       = 1;
      phase_changes = 0;
    end
    else if (watch_pattern)
    begin
      check("pattern step", 32'(expected_word(MODE_PATTERN, '0, 32'(prev_word) + 32'd1)),
            32'(pins));
      prev_word = pins;
      samples++;
    end
    else if (pins == expected_word(MODE_CAP_TEST, '0, phase_idx))
    begin
      run_len++;
      if (run_len > PHASE_CLKS)
        check("cap phase length", PHASE_CLKS, run_len);
    end
    else
    begin
      // the phase seen at arming may be partial
      if (phase_changes > 0)
        check("cap phase length", PHASE_CLKS, run_len);
      phase_idx++;
      phase_changes++;
      check("cap phase word", 32'(expected_word(MODE_CAP_TEST, '0, phase_idx)), 32'(pins));
      run_len = 1;
    end
  end

  ////////////////////////////////////////
  // tests

  task automatic test_readback();
    reg_word_t led_val;
    reg_word_t mux_val;
    reg_word_t mode_val;
    reg_word_t dir_val;
    rng = xorshift32(rng);
    led_val = rng[23:0];
    rng = xorshift32(rng);
    mux_val = rng[23:0];
    rng = xorshift32(rng);
    mode_val = rng[23:0];
    rng = xorshift32(rng);
    dir_val = rng[23:0];
    spi_write(`DMM_ADDR_LED, led_val);
    spi_write(`DMM_ADDR_SPI_MUX, mux_val);
    spi_write(`DMM_ADDR_MODE, mode_val);
    spi_write(`DMM_ADDR_DIRECT, dir_val);
    read_and_check("readback led", `DMM_ADDR_LED, led_val);
    // one bit per channel is kept
    read_and_check("readback spi mux", `DMM_ADDR_SPI_MUX,
                   reg_word_t'(mux_val[`DMM_NUM_PERIPH-1:0]));
    read_and_check("readback mode", `DMM_ADDR_MODE, mode_val);
    read_and_check("readback direct", `DMM_ADDR_DIRECT, dir_val);
    read_and_check("readback unknown", 8'd3, '0);
    end_test("readback");
  endtask

  task automatic test_direct();
    reg_word_t   dval;
    out_word_t   held;
    logic [31:0] rx;
    int          n;
    spi_write(`DMM_ADDR_MODE, 24'(`DMM_MODE_DIRECT));
    for (int i = 0; i < 5; i++)
    begin
      rng = xorshift32(rng);
      // bit 0 set keeps the pins off zero for the pattern entry
      dval = rng[23:0] | 24'h000001;
      spi_write(`DMM_ADDR_DIRECT, dval);
      wait_for_pins("direct word", expected_word(MODE_DIRECT, dval, 0));
    end
    held = pins;
    spi_frame({`DMM_ADDR_DIRECT, ~dval}, 20, rx);
    n = 0;
    while (pins === held && n < WAIT_CLKS)
    begin
      @(negedge clk);
      n++;
    end
    check("short frame pins", 32'(held), 32'(pins));
    read_and_check("short frame readback", `DMM_ADDR_DIRECT, dval);
    end_test("direct");
  endtask

  task automatic test_pattern();
    spi_write(`DMM_ADDR_MODE, 24'(`DMM_MODE_PATTERN));
    wait_for_pins("pattern entry", expected_word(MODE_PATTERN, '0, 0));
    samples = 0;
    watch_pattern = 1'b1;
    for (int i = 0; i < 60; i++)
      @(negedge clk);
    watch_pattern = 1'b0;
    check("pattern samples seen", 1, 32'(samples > 40));
    end_test("pattern");
  endtask

  task automatic test_cap();
    spi_write(`DMM_ADDR_MODE, 24'(`DMM_MODE_CAP_TEST));
    wait_for_pins("cap entry", expected_word(MODE_CAP_TEST, '0, 0));
    watch_cap = 1'b1;
    for (int i = 0; i < 5 * PHASE_CLKS + 5; i++)
      @(negedge clk);
    watch_cap = 1'b0;
    check("cap phase changes seen", 1, 32'(phase_changes >= 4));
    end_test("cap test");
  endtask

  task automatic test_periph();
    periph_vec_t exp_cs;
    logic [2:0]  ch;
    spi_write(`DMM_ADDR_MODE, 24'(`DMM_MODE_OFF));
    wait_for_pins("off word", expected_word(MODE_OFF, '0, 0));
    for (int k = 0; k < 6; k++)
    begin
      rng = xorshift32(rng);
      ch = rng[2:0];
      spi_write(`DMM_ADDR_SPI_MUX, reg_word_t'(channel_vec(ch, 1'b1)));
      exp_cs = CS_IDLE;
      exp_cs[ch] = CS_POL[ch];
      @(negedge clk);
      spi_cs2 = 1'b0;
      for (int b = 0; b < 8; b++)
      begin
        rng = xorshift32(rng);
        @(negedge clk);
        spi_mosi = rng[0];
        spi_clk = rng[1];
        periph_miso = rng[15:8];
        @(posedge clk);
        check("periph strobe", 32'(exp_cs), 32'(periph_cs));
        check("periph clock", 32'(channel_vec(ch, spi_clk)), 32'(periph_clk));
        check("periph data", 32'(channel_vec(ch, spi_mosi)), 32'(periph_mosi));
        check("periph miso", 32'(periph_miso[ch]), 32'(spi_miso));
      end
      @(negedge clk);
      spi_cs2 = 1'b1;
      spi_clk = 1'b0;
      spi_mosi = 1'b0;
      @(posedge clk);
      check("idle strobes", 32'(CS_IDLE), 32'(periph_cs));
      check("idle clock and data", 0, 32'(periph_clk | periph_mosi));
      check("idle miso", 0, 32'(spi_miso));
    end
    check("off word held", 0, 32'(pins));
    end_test("peripheral");
  endtask

  ////////////////////////////////////////
  // main sequence

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    spi_clk = 1'b0;
    spi_cs = 1'b1;
    spi_mosi = 1'b0;
    spi_cs2 = 1'b1;
    periph_miso = '0;
    rng = SEED;
    tests = 0;
    checks = 0;
    errors = 0;
    test_checks = 0;
    test_errors = 0;
    watch_pattern = 1'b0;
    watch_cap = 1'b0;
    armed = 1'b0;
    samples = 0;
    phase_changes = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    test_readback();
    test_direct();
    test_pattern();
    test_cap();
    test_periph();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // whole run limit, well above the few dozen frames of the tests
  initial
  begin
    #200000;
    $display("timeout: the run did not reach its end within 200 us");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
verilog/dmm_pkg.sv
verilog/spi_regbank.sv
verilog/periph_spi_mux.sv
verilog/pattern_gen.sv
verilog/cap_test_seq.sv
verilog/mode_ctrl.sv
verilog/dmm_top.sv
tb/dmm_checker.sv
tb/tb_dmm.sv

// ==== run.sh ====
#!/bin/sh
# builds the dmm testbench with verilator and runs it, pass is read from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_dmm -o tb_dmm_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dmm_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
  exit 0
fi
exit 1
